/* Bender.yml */
package:
  name: arcade_control

sources:
  - logic/arcade_pkg.sv
  - logic/boot_sequencer.sv
  - logic/rom_write_port.sv
  - logic/spinner.sv
  - logic/mouse_tracker.sv
  - logic/input_port_mux.sv
  - logic/control_top.sv
  - target: test
    files:
      - test/control_properties.sv
      - test/control_tb.sv

/* files.f */
logic/arcade_pkg.sv
logic/boot_sequencer.sv
logic/rom_write_port.sv
logic/spinner.sv
logic/mouse_tracker.sv
logic/input_port_mux.sv
logic/control_top.sv
test/control_properties.sv
test/control_tb.sv

/* logic/arcade_pkg.sv */
/*
 * Shared types and constants for the arcade control front end.
 * Widths are fixed by the game boards and are not meant to be changed.
 * All control struct bits are active high; inversion to the board's
 * active-low levels happens only in the input port mux.
 */
`default_nettype none

package arcade_pkg;

	// ======================================================================
	// Constants
	// ======================================================================
	localparam int MEM_CREDITS       = 4;
	localparam int CREDIT_W          = 3;
	localparam int SPIN_ACCEL_FRAMES = 8;
	localparam int PTR_W             = 10;
	localparam int TRACK_W           = 11;

	// ======================================================================
	// Enums
	// ======================================================================
	typedef enum logic [2:0] {
		GAME_SHOLLOW  = 3'd0,
		GAME_TRON     = 3'd1,
		GAME_TWOTIGER = 3'd2,
		GAME_WACKO    = 3'd3,
		GAME_KROOZR   = 3'd4,
		GAME_DOMINO   = 3'd5
	} game_id_t;

	typedef enum logic [1:0] {
		BOOT_EMPTY   = 2'd0,
		BOOT_LOADING = 2'd1,
		BOOT_DRAIN   = 2'd2,
		BOOT_RUNNING = 2'd3
	} boot_state_t;

	// ======================================================================
	// Structs
	// ======================================================================
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
	} player_ctrl_t;

	typedef struct packed {
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
		logic start3;
		logic tilt;
		logic service;
	} cabinet_ctrl_t;

	typedef struct packed {
		logic signed [8:0] dx;
		logic signed [8:0] dy;
		logic [1:0]        buttons;
	} mouse_event_t;

	// Byte address from the download link, not word address
	typedef struct packed {
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_byte_t;

	typedef struct packed {
		logic        valid;
		logic [22:0] addr;
		logic [15:0] data;
		logic [1:0]  be;
	} mem_write_t;

	// Index 0 is game input port 0
	typedef logic [4:0][7:0] input_ports_t;

endpackage

`default_nettype wire

/* logic/boot_sequencer.sv */
/*
 * Boot sequencer. Keeps the game board in reset until a download has
 * completed and every memory write has been acknowledged.
 * reset_game is registered, so it follows the state one cycle late.
 * A new download restarts the sequence from any state.
 */
`timescale 1ns/1ps
`default_nettype none

module boot_sequencer
	import arcade_pkg::*;
(
	input  wire  clk_sys,
	input  wire  rst_n,
	input  wire  dl_active,
	input  wire  writes_idle,
	input  wire  reset_req,
	output logic reset_game
);

	boot_state_t state;
	boot_state_t state_nxt;
	logic        dl_active_d;
	logic        dl_rise;
	logic        dl_fall;

	assign dl_rise = dl_active & ~dl_active_d;
	assign dl_fall = ~dl_active & dl_active_d;

	always_comb begin
		state_nxt = state;
		if (dl_rise) begin
			state_nxt = BOOT_LOADING;
		end else begin
			case (state)
				BOOT_EMPTY:   state_nxt = BOOT_EMPTY;
				BOOT_LOADING: if (dl_fall) state_nxt = BOOT_DRAIN;
				// Wait for the last credit to come home
				BOOT_DRAIN:   if (writes_idle) state_nxt = BOOT_RUNNING;
				BOOT_RUNNING: state_nxt = BOOT_RUNNING;
				default:      state_nxt = BOOT_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state       <= BOOT_EMPTY;
			dl_active_d <= 1'b0;
			reset_game  <= 1'b1;
		end else begin
			state       <= state_nxt;
			dl_active_d <= dl_active;
			// dl_active term catches a new download while running
			reset_game  <= (state != BOOT_RUNNING) | reset_req | dl_active;
		end
	end

endmodule

`default_nettype wire

/* logic/control_top.sv */
/*
 * Control front end top level. Download path, boot sequencing,
 * spinners, mouse tracking and game input ports.
 * The memory side must return one credit per write it has completed.
 * frame_tick is expected as a single-cycle pulse per vertical sync.
 */
`timescale 1ns/1ps
`default_nettype none

module control_top
	import arcade_pkg::*;
(
	input  wire           clk_sys,
	input  wire           rst_n,
	input  wire           dl_active,
	input  wire           dl_valid,
	input  dl_byte_t      dl,
	input  wire           credit_return,
	input  wire           reset_req,
	input  game_id_t      game,
	input  wire           rotate,
	input  wire           frame_tick,
	input  cabinet_ctrl_t cab,
	input  player_ctrl_t  p1,
	input  player_ctrl_t  p2,
	input  wire           mouse_strobe,
	input  mouse_event_t  mouse,
	output logic          reset_game,
	output logic          dl_ready,
	output mem_write_t    mem_wr,
	output input_ports_t  ports,
	output logic [6:0]    spin1,
	output logic [6:0]    spin2
);

	logic                      writes_idle;
	logic signed [TRACK_W-1:0] track_x;
	logic signed [TRACK_W-1:0] track_y;
	logic signed [PTR_W-1:0]   ptr_x;
	logic signed [PTR_W-1:0]   ptr_y;
	logic [1:0]                mouse_buttons;

	// ======================================================================
	// Download and boot
	// ======================================================================
	rom_write_port u_rom_write_port (
		.clk_sys(clk_sys), .rst_n(rst_n), .dl_valid(dl_valid), .dl(dl),
		.credit_return(credit_return), .dl_ready(dl_ready), .mem_wr(mem_wr),
		.writes_idle(writes_idle)
	);

	boot_sequencer u_boot_sequencer (
		.clk_sys(clk_sys), .rst_n(rst_n), .dl_active(dl_active),
		.writes_idle(writes_idle), .reset_req(reset_req), .reset_game(reset_game)
	);

	// ======================================================================
	// Controls
	// ======================================================================
	spinner u_spinner1 (
		.clk_sys(clk_sys), .rst_n(rst_n), .frame_tick(frame_tick),
		.turn_ccw(p1.left | p1.up), .turn_cw(p1.right | p1.down), .angle(spin1)
	);

	spinner u_spinner2 (
		.clk_sys(clk_sys), .rst_n(rst_n), .frame_tick(frame_tick),
		.turn_ccw(p2.left | p2.up), .turn_cw(p2.right | p2.down), .angle(spin2)
	);

	mouse_tracker u_mouse_tracker (
		.clk_sys(clk_sys), .rst_n(rst_n), .rotate(rotate),
		.mouse_strobe(mouse_strobe), .mouse(mouse),
		.track_x(track_x), .track_y(track_y), .ptr_x(ptr_x), .ptr_y(ptr_y),
		.mouse_buttons(mouse_buttons)
	);

	input_port_mux u_input_port_mux (
		.clk_sys(clk_sys), .rst_n(rst_n), .game(game), .cab(cab),
		.p1(p1), .p2(p2), .spin1(spin1), .spin2(spin2),
		.track_x(track_x), .track_y(track_y), .ptr_x(ptr_x), .ptr_y(ptr_y),
		.mouse_buttons(mouse_buttons), .ports(ports)
	);

endmodule

`default_nettype wire

/* logic/input_port_mux.sv */
/*
 * Game input port mapping. Five 8-bit active-low ports, registered.
 * Button bits are inverted here; position bytes go out as raw values,
 * as the boards read them. DIP switch bits are fixed to factory values.
 * Port 0 keeps one layout for all games, only bit 4 differs per game.
 */
`timescale 1ns/1ps
`default_nettype none

module input_port_mux
	import arcade_pkg::*;
(
	input  wire                       clk_sys,
	input  wire                       rst_n,
	input  game_id_t                  game,
	input  cabinet_ctrl_t             cab,
	input  player_ctrl_t              p1,
	input  player_ctrl_t              p2,
	input  wire [6:0]                 spin1,
	input  wire [6:0]                 spin2,
	input  wire signed [TRACK_W-1:0]  track_x,
	input  wire signed [TRACK_W-1:0]  track_y,
	input  wire signed [PTR_W-1:0]    ptr_x,
	input  wire signed [PTR_W-1:0]    ptr_y,
	input  wire [1:0]                 mouse_buttons,
	output input_ports_t              ports
);

	input_ports_t ports_nxt;
	logic         p0_bit4;

	// Bit 4 of port 0 is the only game-specific bit there
	always_comb begin
		case (game)
			GAME_TRON:     p0_bit4 = p1.fire_a;
			GAME_TWOTIGER: p0_bit4 = cab.start3;
			GAME_KROOZR:   p0_bit4 = p1.fire_a | mouse_buttons[0];
			GAME_DOMINO:   p0_bit4 = p1.fire_a;
			default:       p0_bit4 = 1'b0;
		endcase
	end

	// ======================================================================
	// Per-game wiring
	// ======================================================================
	always_comb begin
		ports_nxt    = {5{8'hFF}};
		ports_nxt[0] = ~{cab.service, 1'b0, cab.tilt, p0_bit4,
			cab.start2, cab.start1, cab.coin2, cab.coin1};
		case (game)
			GAME_SHOLLOW: begin
				ports_nxt[1] = ~{p2.fire_a, p2.fire_b, p2.right, p2.left,
					p1.fire_a, p1.fire_b, p1.right, p1.left};
				ports_nxt[3] = ~8'b0000_0010;
			end
			GAME_TRON: begin
				ports_nxt[1] = ~{1'b0, spin1};
				ports_nxt[2] = ~{p2.down, p2.up, p2.right, p2.left,
					p1.down, p1.up, p1.right, p1.left};
				ports_nxt[3] = ~{p1.fire_a, 7'b000_0010};
				ports_nxt[4] = ~{1'b0, spin2};
			end
			GAME_TWOTIGER: begin
				ports_nxt[1] = ~{1'b0, spin1};
				ports_nxt[2] = ~{4'b0000, p2.fire_b, p2.fire_a, p1.fire_b, p1.fire_a};
				ports_nxt[4] = ~{1'b0, spin2};
			end
			GAME_WACKO: begin
				// Trackball, top 8 bits only
				ports_nxt[1] = track_x[TRACK_W-1:3];
				ports_nxt[2] = track_y[TRACK_W-1:3];
				ports_nxt[3] = ~8'b0100_0000;
				ports_nxt[4] = ~{p2.up, p2.down, p2.left, p2.right,
					p1.up, p1.down, p1.left, p1.right};
			end
			GAME_KROOZR: begin
				ports_nxt[1] = ~{p1.fire_b | mouse_buttons[1], spin1[6], 3'b111, spin1[5:3]};
				ports_nxt[2] = {ptr_x[PTR_W-1], ptr_x[PTR_W-1], ptr_x[7:2]};
				ports_nxt[3] = ~8'b0100_0000;
				ports_nxt[4] = {ptr_y[PTR_W-1], ptr_y[PTR_W-1], ptr_y[7:2]};
			end
			GAME_DOMINO: begin
				ports_nxt[1] = ~{4'b0000, p1.down, p1.up, p1.right, p1.left};
				ports_nxt[2] = ~{3'b000, p2.fire_a, p2.down, p2.up, p2.right, p2.left};
				ports_nxt[3] = ~8'b0100_0000;
			end
			default: ports_nxt = {5{8'hFF}};
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ports <= {5{8'hFF}};
		end else begin
			ports <= ports_nxt;
		end
	end

endmodule

`default_nettype wire

/* logic/mouse_tracker.sv */
/*
 * Mouse motion accumulator. The trackball position wraps freely and
 * the pointer position is clamped by dropping any update that would
 * overflow a signed PTR_W value. The pointer x axis runs opposite to
 * the mouse. With rotate set the axes are swapped for a turned screen.
 */
`timescale 1ns/1ps
`default_nettype none

module mouse_tracker
	import arcade_pkg::*;
(
	input  wire                       clk_sys,
	input  wire                       rst_n,
	input  wire                       rotate,
	input  wire                       mouse_strobe,
	input  mouse_event_t              mouse,
	output logic signed [TRACK_W-1:0] track_x,
	output logic signed [TRACK_W-1:0] track_y,
	output logic signed [PTR_W-1:0]   ptr_x,
	output logic signed [PTR_W-1:0]   ptr_y,
	output logic [1:0]                mouse_buttons
);

	// One extra bit so that negating -256 stays exact
	logic signed [9:0]     dx_ext;
	logic signed [9:0]     dy_ext;
	logic signed [9:0]     move_x;
	logic signed [9:0]     move_y;
	logic signed [PTR_W:0] ptr_x_sum;
	logic signed [PTR_W:0] ptr_y_sum;
	logic                  ptr_x_ok;
	logic                  ptr_y_ok;

	assign dx_ext = mouse.dx;
	assign dy_ext = mouse.dy;
	assign move_x = rotate ? -dy_ext : dx_ext;
	assign move_y = rotate ? dx_ext : dy_ext;

	assign ptr_x_sum = ptr_x - move_x;
	assign ptr_y_sum = ptr_y + move_y;
	// Sum fits when the two top bits agree
	assign ptr_x_ok  = (ptr_x_sum[PTR_W] == ptr_x_sum[PTR_W-1]);
	assign ptr_y_ok  = (ptr_y_sum[PTR_W] == ptr_y_sum[PTR_W-1]);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			track_x       <= '0;
			track_y       <= '0;
			ptr_x         <= '0;
			ptr_y         <= '0;
			mouse_buttons <= '0;
		end else if (mouse_strobe) begin
			track_x       <= track_x + move_x;
			track_y       <= track_y + move_y;
			mouse_buttons <= mouse.buttons;
			if (ptr_x_ok) ptr_x <= ptr_x_sum[PTR_W-1:0];
			if (ptr_y_ok) ptr_y <= ptr_y_sum[PTR_W-1:0];
		end
	end

endmodule

`default_nettype wire

/* logic/rom_write_port.sv */
/*
 * Download byte to memory write converter with credit flow control.
 * A credit is taken when a byte is accepted, so dl_ready drops in the
 * same cycle the last credit is used. The write appears one cycle later.
 * The memory returns one credit_return pulse per completed write.
 * Only address bits 23:1 reach the memory, bit 24 is ignored.
 */
`timescale 1ns/1ps
`default_nettype none

module rom_write_port
	import arcade_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        dl_valid,
	input  dl_byte_t   dl,
	input  wire        credit_return,
	output logic       dl_ready,
	output mem_write_t mem_wr,
	output logic       writes_idle
);

	logic [CREDIT_W-1:0] credit_cnt;
	logic                accept;
	logic                wr_valid;
	logic [22:0]         wr_addr;
	logic [15:0]         wr_data;
	logic [1:0]          wr_be;

	assign dl_ready    = (credit_cnt != '0);
	assign accept      = dl_valid & dl_ready;
	assign writes_idle = (credit_cnt == CREDIT_W'(MEM_CREDITS)) & ~wr_valid;

	// ======================================================================
	// Credit counter
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			credit_cnt <= CREDIT_W'(MEM_CREDITS);
		end else if (accept && !credit_return) begin
			credit_cnt <= credit_cnt - 1'b1;
		end else if (credit_return && !accept) begin
			// Saturate in case of a stray return
			if (credit_cnt != CREDIT_W'(MEM_CREDITS))
				credit_cnt <= credit_cnt + 1'b1;
		end
	end

	// ======================================================================
	// Write issue
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_valid <= 1'b0;
		end else begin
			wr_valid <= accept;
		end
	end

	// Byte copied to both halves, byte enable picks the half
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			wr_addr <= dl.addr[23:1];
			wr_data <= {dl.data, dl.data};
			wr_be   <= {dl.addr[0], ~dl.addr[0]};
		end
	end

	assign mem_wr = {wr_valid, wr_addr, wr_data, wr_be};

endmodule

`default_nettype wire

/* logic/spinner.sv */
/*
 * Rotary spinner emulation from two direction buttons.
 * The angle moves only on frame_tick: by 1 at first, by 2 once the same
 * direction has been held for SPIN_ACCEL_FRAMES ticks. Wraps modulo 128.
 * Both or neither button held stops the spinner and resets acceleration.
 */
`timescale 1ns/1ps
`default_nettype none

module spinner
	import arcade_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        frame_tick,
	input  wire        turn_ccw,
	input  wire        turn_cw,
	output logic [6:0] angle
);

	logic [$clog2(SPIN_ACCEL_FRAMES + 1)-1:0] hold_cnt;
	logic [$clog2(SPIN_ACCEL_FRAMES + 1)-1:0] hold_eff;
	logic                                     hold_cw;
	logic                                     one_held;
	logic [6:0]                               step;

	assign one_held = turn_ccw ^ turn_cw;
	// Reversing direction counts as a fresh hold
	assign hold_eff = (turn_cw == hold_cw) ? hold_cnt : '0;
	assign step     = (hold_eff >= SPIN_ACCEL_FRAMES) ? 7'd2 : 7'd1;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hold_cnt <= '0;
			hold_cw  <= 1'b0;
			angle    <= '0;
		end else if (!one_held) begin
			hold_cnt <= '0;
		end else begin
			hold_cw  <= turn_cw;
			hold_cnt <= hold_eff;
			if (frame_tick) begin
				angle <= turn_cw ? angle + step : angle - step;
				// Saturate once acceleration is reached
				if (hold_eff < SPIN_ACCEL_FRAMES)
					hold_cnt <= hold_eff + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* test/control_properties.sv */
/*
 * Concurrent checks bound into the write port and the boot sequencer.
 * Each bind enables only the group of checks that fits its target and
 * ties the other inputs off.
 */
`timescale 1ns/1ps
`default_nettype none

module control_properties
	import arcade_pkg::*;
(
	input wire                clk_sys,
	input wire                rst_n,
	input wire                credit_check,
	input wire [CREDIT_W-1:0] credit_cnt,
	input wire                wr_valid,
	input wire                boot_check,
	input wire                dl_active,
	input wire                reset_game
);

	int unsigned violations = 0;

	// ======================================================================
	// Credit flow
	// ======================================================================

	// Credit is spent on the accept cycle before the write
	write_has_credit: assert property (@(posedge clk_sys) disable iff (!rst_n || !credit_check)
		wr_valid |-> $past(credit_cnt) != '0)
	else begin
		$error("memory write issued without a credit");
		violations++;
	end

	credit_bounded: assert property (@(posedge clk_sys) disable iff (!rst_n || !credit_check)
		credit_cnt <= CREDIT_W'(MEM_CREDITS))
	else begin
		$error("credit count above the memory buffer depth");
		violations++;
	end

	// ======================================================================
	// Boot hold
	// ======================================================================

	// No release while a download is active
	game_held_while_loading: assert property (@(posedge clk_sys) disable iff (!rst_n || !boot_check)
		dl_active |-> reset_game)
	else begin
		$error("game released while a download is active");
		violations++;
	end

endmodule

bind rom_write_port control_properties u_wport_props (
	.clk_sys(clk_sys),
	.rst_n(rst_n),
	.credit_check(1'b1),
	.credit_cnt(credit_cnt),
	.wr_valid(mem_wr.valid),
	.boot_check(1'b0),
	.dl_active(1'b0),
	.reset_game(1'b1)
);

bind boot_sequencer control_properties u_boot_props (
	.clk_sys(clk_sys),
	.rst_n(rst_n),
	.credit_check(1'b0),
	.credit_cnt('0),
	.wr_valid(1'b0),
	.boot_check(1'b1),
	.dl_active(dl_active),
	.reset_game(reset_game)
);

`default_nettype wire

/* test/control_tb.sv */
/*
 * Testbench for the arcade control front end.
 * Reference models cover the download path, boot release, spinners,
 * mouse tracking and the per-game port wiring.
 * The memory model returns each credit 1 to 6 cycles after its write.
 * Mouse positions are read from wires inside the top level.
 */
`timescale 1ns/1ps
`default_nettype none

module control_tb
	import arcade_pkg::*;
();

	logic          clk_sys;
	logic          rst_n;
	logic          dl_active;
	logic          dl_valid;
	dl_byte_t      dl;
	logic          credit_return;
	logic          reset_req;
	game_id_t      game;
	logic          rotate;
	logic          frame_tick;
	cabinet_ctrl_t cab;
	player_ctrl_t  p1;
	player_ctrl_t  p2;
	logic          mouse_strobe;
	mouse_event_t  mouse;
	logic          reset_game;
	logic          dl_ready;
	mem_write_t    mem_wr;
	input_ports_t  ports;
	logic [6:0]    spin1;
	logic [6:0]    spin2;

	integer             seed = 32'hf05c_a5df;
	int                 wait_limit = 100;
	int                 waited;
	int                 i;
	int                 gi;
	// Reference model state
	mem_write_t         exp_wr_q[$];
	mem_write_t         exp_write;
	int                 due_q[$];
	int                 cyc = 0;
	int                 outstanding = 0;
	logic [6:0]         exp_spin1;
	logic [6:0]         exp_spin2;
	logic [TRACK_W-1:0] exp_track_x;
	logic [TRACK_W-1:0] exp_track_y;
	int                 exp_ptr_x;
	int                 exp_ptr_y;
	logic [1:0]         exp_buttons;

	control_top UUT (
		.clk_sys(clk_sys), .rst_n(rst_n), .dl_active(dl_active), .dl_valid(dl_valid),
		.dl(dl), .credit_return(credit_return), .reset_req(reset_req), .game(game),
		.rotate(rotate), .frame_tick(frame_tick), .cab(cab), .p1(p1), .p2(p2),
		.mouse_strobe(mouse_strobe), .mouse(mouse), .reset_game(reset_game),
		.dl_ready(dl_ready), .mem_wr(mem_wr), .ports(ports), .spin1(spin1), .spin2(spin2)
	);

	always #20 clk_sys = ~clk_sys;

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else stop_on_error($sformatf("[FAIL] time %0t: %s expected 'h%0h, actual 'h%0h",
			$time, name, expected, actual));
	endtask

	// ======================================================================
	// Memory model with delayed credit returns
	// ======================================================================
	always @(negedge clk_sys) begin
		if (rst_n) begin
			if (credit_return)
				outstanding--;
			if (mem_wr.valid) begin
				outstanding++;
				if (exp_wr_q.size() == 0) begin
					stop_on_error("memory write seen without an accepted byte");
				end else begin
					exp_write = exp_wr_q.pop_front();
					check_value("mem_wr.addr", exp_write.addr, mem_wr.addr);
					check_value("mem_wr.data", exp_write.data, mem_wr.data);
					check_value("mem_wr.be", exp_write.be, mem_wr.be);
					due_q.push_back(cyc + 1 + {$random(seed)} % 6);
				end
			end
			assert (outstanding <= MEM_CREDITS)
			else stop_on_error($sformatf("[FAIL] time %0t: outstanding writes limit %0d, actual %0d",
				$time, MEM_CREDITS, outstanding));
			credit_return = 1'b0;
			if (due_q.size() != 0 && due_q[0] <= cyc) begin
				credit_return = 1'b1;
				due_q.delete(0);
			end
			cyc++;
		end
	end

	always @(negedge clk_sys) begin
		if (UUT.u_rom_write_port.u_wport_props.violations != 0 ||
			UUT.u_boot_sequencer.u_boot_props.violations != 0)
			stop_on_error("a bound property check failed");
	end

	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		mem_write_t wr;
		int         stall;
		dl_valid = 1'b1;
		dl.addr  = addr;
		dl.data  = data;
		stall    = 0;
		// Slow credits make the source wait here
		while (!dl_ready) begin
			@(negedge clk_sys);
			stall++;
			if (stall > wait_limit)
				stop_on_error("timeout: dl_ready stayed low while a byte was offered");
		end
		wr.valid = 1'b1;
		wr.addr  = addr[23:1];
		wr.data  = {data, data};
		wr.be    = addr[0] ? 2'b10 : 2'b01;
		exp_wr_q.push_back(wr);
		@(negedge clk_sys);
		dl_valid = 1'b0;
	endtask

	task automatic turn_spinner(input logic cw, input int ticks);
		int held;
		int step;
		int k;
		// Release first so that acceleration starts over
		p1 = '0;
		p2 = '0;
		@(negedge clk_sys);
		held     = 0;
		p1.right = cw;
		p1.left  = !cw;
		// Player 2 turns the same way through down and up
		p2.down  = cw;
		p2.up    = !cw;
		@(negedge clk_sys);
		for (k = 0; k < ticks; k++) begin
			frame_tick = 1'b1;
			@(negedge clk_sys);
			frame_tick = 1'b0;
			step = (held >= SPIN_ACCEL_FRAMES) ? 2 : 1;
			held++;
			exp_spin1 = cw ? exp_spin1 + step : exp_spin1 - step;
			exp_spin2 = cw ? exp_spin2 + step : exp_spin2 - step;
			check_value("spin1", exp_spin1, spin1);
			check_value("spin2", exp_spin2, spin2);
			@(negedge clk_sys);
			check_value("spin1 between ticks", exp_spin1, spin1);
			check_value("spin2 between ticks", exp_spin2, spin2);
		end
		p1 = '0;
		p2 = '0;
	endtask

	task automatic move_mouse(input logic rot);
		int dxi;
		int dyi;
		int mx;
		int my;
		int sum_x;
		int sum_y;
		int lim;
		lim           = 1 << (PTR_W - 1);
		rotate        = rot;
		mouse.dx      = 9'($random(seed));
		mouse.dy      = 9'($random(seed));
		mouse.buttons = 2'($random(seed));
		mouse_strobe  = 1'b1;
		dxi = $signed(mouse.dx);
		dyi = $signed(mouse.dy);
		mx  = rot ? -dyi : dxi;
		my  = rot ? dxi : dyi;
		exp_track_x = exp_track_x + mx;
		exp_track_y = exp_track_y + my;
		// Pointer x runs against the mouse
		// An overflowing update keeps the old value
		sum_x = exp_ptr_x - mx;
		sum_y = exp_ptr_y + my;
		if (sum_x >= -lim && sum_x < lim)
			exp_ptr_x = sum_x;
		if (sum_y >= -lim && sum_y < lim)
			exp_ptr_y = sum_y;
		exp_buttons = mouse.buttons;
		@(negedge clk_sys);
		mouse_strobe = 1'b0;
		check_value("track_x", exp_track_x, $unsigned(UUT.track_x));
		check_value("track_y", exp_track_y, $unsigned(UUT.track_y));
		check_value("ptr_x", $unsigned(PTR_W'(exp_ptr_x)), $unsigned(UUT.ptr_x));
		check_value("ptr_y", $unsigned(PTR_W'(exp_ptr_y)), $unsigned(UUT.ptr_y));
		check_value("mouse_buttons", exp_buttons, UUT.mouse_buttons);
	endtask

	// ======================================================================
	// Port mapping table
	// ======================================================================
	function automatic input_ports_t expected_ports(input game_id_t g);
		input_ports_t e;
		logic         b4;
		e = {5{8'hFF}};
		case (g)
			GAME_TRON:     b4 = p1.fire_a;
			GAME_TWOTIGER: b4 = cab.start3;
			GAME_KROOZR:   b4 = p1.fire_a | exp_buttons[0];
			GAME_DOMINO:   b4 = p1.fire_a;
			default:       b4 = 1'b0;
		endcase
		// Same port 0 layout on every board
		e[0] = ~{cab.service, 1'b0, cab.tilt, b4, cab.start2, cab.start1, cab.coin2, cab.coin1};
		case (g)
			GAME_SHOLLOW: begin
				e[1] = ~{p2.fire_a, p2.fire_b, p2.right, p2.left,
					p1.fire_a, p1.fire_b, p1.right, p1.left};
				e[3] = 8'hFD;
			end
			GAME_TRON: begin
				e[1] = ~{1'b0, exp_spin1};
				e[2] = ~{p2.down, p2.up, p2.right, p2.left, p1.down, p1.up, p1.right, p1.left};
				e[3] = ~{p1.fire_a, 7'h02};
				e[4] = ~{1'b0, exp_spin2};
			end
			GAME_TWOTIGER: begin
				e[1] = ~{1'b0, exp_spin1};
				e[2] = ~{4'h0, p2.fire_b, p2.fire_a, p1.fire_b, p1.fire_a};
				e[4] = ~{1'b0, exp_spin2};
			end
			GAME_WACKO: begin
				e[1] = exp_track_x[TRACK_W-1:3];
				e[2] = exp_track_y[TRACK_W-1:3];
				e[3] = 8'hBF;
				e[4] = ~{p2.up, p2.down, p2.left, p2.right, p1.up, p1.down, p1.left, p1.right};
			end
			GAME_KROOZR: begin
				e[1] = ~{p1.fire_b | exp_buttons[1], exp_spin1[6], 3'b111, exp_spin1[5:3]};
				e[2] = {exp_ptr_x[PTR_W-1], exp_ptr_x[PTR_W-1], exp_ptr_x[7:2]};
				e[3] = 8'hBF;
				e[4] = {exp_ptr_y[PTR_W-1], exp_ptr_y[PTR_W-1], exp_ptr_y[7:2]};
			end
			GAME_DOMINO: begin
				e[1] = ~{4'h0, p1.down, p1.up, p1.right, p1.left};
				e[2] = ~{3'b000, p2.fire_a, p2.down, p2.up, p2.right, p2.left};
				e[3] = 8'hBF;
			end
			default: e = {5{8'hFF}};
		endcase
		return e;
	endfunction

	task automatic check_ports(input game_id_t g);
		input_ports_t expected;
		int           n;
		game = g;
		cab  = 7'($random(seed));
		p1   = 6'($random(seed));
		p2   = 6'($random(seed));
		@(negedge clk_sys);
		expected = expected_ports(g);
		for (n = 0; n < 5; n++)
			check_value($sformatf("ports[%0d]", n), expected[n], ports[n]);
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial begin
		clk_sys       = 1'b0;
		rst_n         = 1'b0;
		dl_active     = 1'b0;
		dl_valid      = 1'b0;
		dl            = '0;
		credit_return = 1'b0;
		reset_req     = 1'b0;
		game          = GAME_SHOLLOW;
		rotate        = 1'b0;
		frame_tick    = 1'b0;
		cab           = '0;
		p1            = '0;
		p2            = '0;
		mouse_strobe  = 1'b0;
		mouse         = '0;
		exp_spin1     = '0;
		exp_spin2     = '0;
		exp_track_x   = '0;
		exp_track_y   = '0;
		exp_ptr_x     = 0;
		exp_ptr_y     = 0;
		exp_buttons   = '0;
		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;

		// Values straight out of reset
		check_value("reset_game", 1, reset_game);
		check_value("mem_wr.valid", 0, mem_wr.valid);
		check_value("dl_ready", 1, dl_ready);
		check_value("spin1", 0, spin1);
		check_value("spin2", 0, spin2);
		check_value("track_x", 0, $unsigned(UUT.track_x));
		check_value("ptr_x", 0, $unsigned(UUT.ptr_x));
		for (i = 0; i < 5; i++)
			check_value($sformatf("ports[%0d]", i), 8'hFF, ports[i]);

		// Download of 64 bytes against the slow memory
		dl_active = 1'b1;
		for (i = 0; i < 64; i++) begin
			send_byte(25'h00_2000 + i, 8'($random(seed)));
			check_value("reset_game during download", 1, reset_game);
		end
		dl_active = 1'b0;

		// Release only after the last credit is home
		waited = 0;
		while (reset_game) begin
			@(negedge clk_sys);
			waited++;
			if (waited > wait_limit)
				stop_on_error("timeout: reset_game never released after the download");
		end
		check_value("outstanding writes at release", 0, outstanding);
		check_value("unmatched accepted bytes", 0, exp_wr_q.size());

		reset_req = 1'b1;
		waited    = 0;
		while (!reset_game) begin
			@(negedge clk_sys);
			waited++;
			if (waited > 4)
				stop_on_error("timeout: reset_req did not raise reset_game");
		end
		reset_req = 1'b0;

		// 8 ticks at step 1, then 4 at step 2
		turn_spinner(1'b1, 12);
		check_value("spin1 after 12 ticks right", 16, spin1);
		turn_spinner(1'b0, 20);
		check_value("spin1 after wrapping below zero", 112, spin1);
		check_value("spin2", exp_spin2, spin2);

		for (i = 0; i < 80; i++)
			move_mouse(i >= 40);

		for (gi = 0; gi < 6; gi++)
			repeat (8) check_ports(game_id_t'(gi));

		if (UUT.u_rom_write_port.u_wport_props.violations != 0 ||
			UUT.u_boot_sequencer.u_boot_props.violations != 0) begin
			stop_on_error("a bound property check failed during the run");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
